//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= riscLockTb
FILELIST  ?= riscLock.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSMSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/branchCompare.sv
`timescale 1ns/1ps
`default_nettype none

module branchCompare (
	input  logic [riscLockPkg::XLEN-1:0] rs1Data,
	input  logic [riscLockPkg::XLEN-1:0] rs2Data,
	input  riscLockPkg::branch_t         cond,
	output logic                         takeBranch
);
	import riscLockPkg::*;

	logic isEqual;
	logic ltSigned;
	logic ltUnsigned;

	assign isEqual = rs1Data == rs2Data;
	assign ltSigned = $signed(rs1Data) < $signed(rs2Data);
	assign ltUnsigned = rs1Data < rs2Data;

	always_comb
	begin
		case (cond)
			BEQ:  takeBranch = isEqual;
			BNE:  takeBranch = !isEqual;
			BLT:  takeBranch = ltSigned;
			BGE:  takeBranch = !ltSigned;
			BLTU: takeBranch = ltUnsigned;
			BGEU: takeBranch = !ltUnsigned;
			default:
				takeBranch = 1'b0;  // funct3 010 and 011 never branch
		endcase
	end

endmodule

`default_nettype wire

//--- hw/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm #(
	parameter int IMEM_ADDR_W = 9
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               start,
	input  logic                               go,
	input  logic [riscLockPkg::XLEN-1:0]       startPC,
	input  logic [riscLockPkg::XLEN-1:0]       instrData,
	input  logic [riscLockPkg::XLEN-1:0]       aluResult,
	input  logic                               takeBranch,
	input  logic [riscLockPkg::XLEN-1:0]       rs1Data,
	input  logic [riscLockPkg::XLEN-1:0]       rs2Data,
	output logic [IMEM_ADDR_W-1:0]             instrAddr,
	output logic [riscLockPkg::REG_ADDR_W-1:0] rs1Addr,
	output logic [riscLockPkg::REG_ADDR_W-1:0] rs2Addr,
	output logic [riscLockPkg::REG_ADDR_W-1:0] rdAddr,
	output logic [riscLockPkg::XLEN-1:0]       rdData,
	output logic [riscLockPkg::XLEN-1:0]       operandB,
	output logic                               writeEn,
	output riscLockPkg::funct3_t               funct3,
	output logic                               altOp,
	output logic                               regForm,
	output riscLockPkg::lockCmd_t              lockOut,
	output logic                               done,
	output logic                               error,
	output logic [riscLockPkg::XLEN-1:0]       out1,
	output logic [riscLockPkg::XLEN-1:0]       out2
);
	import riscLockPkg::*;

	state_t          state;
	state_t          nextState;
	opcode_t         opcode;
	logic [XLEN-1:0] ir;       // instruction register
	logic [XLEN-1:0] pc;       // byte address
	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] iImm;
	logic [XLEN-1:0] bImm;
	logic [XLEN-1:0] jImm;

	// instruction fields
	assign opcode = opcode_t'(ir[6:0]);
	assign funct3 = funct3_t'(ir[14:12]);
	assign altOp = ir[30];
	assign regForm = ir[5];  // set for OP_REG, clear for OP_IMM
	assign rdAddr = ir[11:7];

	// sign-extended immediates
	assign iImm = {{(XLEN-12){ir[31]}}, ir[31:20]};
	assign bImm = {{(XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign jImm = {{(XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	assign pcPlus4 = pc + 4;
	assign instrAddr = pc[IMEM_ADDR_W+1:2];  // memory is word indexed

	// halt reads x31 and x30 for the result ports
	assign rs1Addr = (state == DONE) ? REG_ADDR_W'(31) : ir[19:15];
	assign rs2Addr = (state == DONE) ? REG_ADDR_W'(30) : ir[24:20];

	assign operandB = regForm ? rs2Data : iImm;
	assign rdData = (opcode == OP_JAL) ? pcPlus4 : aluResult;  // link address for JAL
	assign writeEn = (state == EXEC) && (opcode inside {OP_IMM, OP_REG, OP_JAL});

	assign done = state == DONE;
	assign error = state == ERROR;

	always_comb
	begin
		lockOut = LOCK_NONE;
		if (state == LOCKWAIT)
			lockOut = LOCK_HOLD;
		else if ((state == EXEC) && (opcode == OP_UNLOCK))
			lockOut = LOCK_RELEASE;  // only the EXEC cycle of unlock
	end

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (start)
					nextState = FETCH;
			FETCH:
				nextState = LATCH;
			LATCH:
				nextState = DECODE;
			DECODE:
			begin
				case (opcode)
					OP_IMM, OP_REG, OP_BRANCH, OP_JAL, OP_UNLOCK:
						nextState = EXEC;
					OP_LOCK:
						nextState = LOCKWAIT;
					OP_HALT:
						nextState = DONE;
					default:
						nextState = ERROR;  // illegal opcode
				endcase
			end
			EXEC:
			begin
				// control transfers update the PC here and skip PCUPDATE
				if ((opcode == OP_BRANCH) || (opcode == OP_JAL))
					nextState = FETCH;
				else
					nextState = PCUPDATE;
			end
			PCUPDATE:
				nextState = FETCH;
			LOCKWAIT:
				if (go)
					nextState = FETCH;
			DONE:
				nextState = DONE;
			ERROR:
				nextState = ERROR;
			default:
				nextState = ERROR;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= IDLE;
			pc <= startPC;
			out1 <= '0;
			out2 <= '0;
		end
		else
		begin
			state <= nextState;
			case (state)
				EXEC:
				begin
					if (opcode == OP_JAL)
						pc <= pc + jImm;
					else if (opcode == OP_BRANCH)
						pc <= takeBranch ? pc + bImm : pcPlus4;
				end
				PCUPDATE:
					pc <= pcPlus4;
				LOCKWAIT:
					if (go)
						pc <= pcPlus4;  // lock moves on as soon as go is seen
				DONE:
				begin
					out1 <= rs1Data;
					out2 <= rs2Data;
				end
				default:
					pc <= pc;
			endcase
		end
	end

	// memory word is valid in LATCH, one cycle after FETCH presented the address
	always_ff @(posedge clk)
	begin
		if (state == LATCH)
			ir <= instrData;
	end

endmodule

`default_nettype wire

//--- hw/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu (
	input  logic [riscLockPkg::XLEN-1:0] rs1Data,
	input  logic [riscLockPkg::XLEN-1:0] operandB,
	input  riscLockPkg::funct3_t         funct3,
	input  logic                         altOp,     // instruction bit 30
	input  logic                         regForm,   // instruction bit 5
	output logic [riscLockPkg::XLEN-1:0] aluResult
);
	import riscLockPkg::*;

	logic [4:0] shamt;
	logic       ltSigned;
	logic       ltUnsigned;

	assign shamt = operandB[4:0];  // only five bits of shift distance
	assign ltSigned = $signed(rs1Data) < $signed(operandB);
	assign ltUnsigned = rs1Data < operandB;

	always_comb
	begin
		case (funct3)
			F3_ADD:
			begin
				// ADDI has no subtract form, bit 30 is part of its immediate
				if (regForm && altOp)
					aluResult = rs1Data - operandB;
				else
					aluResult = rs1Data + operandB;
			end
			F3_SLL:
				aluResult = rs1Data << shamt;
			F3_SLT:
				aluResult = {{(XLEN-1){1'b0}}, ltSigned};
			F3_SLTU:
				aluResult = {{(XLEN-1){1'b0}}, ltUnsigned};
			F3_XOR:
				aluResult = rs1Data ^ operandB;
			F3_SR:
			begin
				// kept as separate statements so the arithmetic shift stays signed
				if (altOp)
					aluResult = $signed(rs1Data) >>> shamt;
				else
					aluResult = rs1Data >> shamt;
			end
			F3_OR:
				aluResult = rs1Data | operandB;
			F3_AND:
				aluResult = rs1Data & operandB;
			default:
				aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              writeEn,
	input  logic [riscLockPkg::REG_ADDR_W-1:0] rs1Addr,
	input  logic [riscLockPkg::REG_ADDR_W-1:0] rs2Addr,
	input  logic [riscLockPkg::REG_ADDR_W-1:0] rdAddr,
	input  logic [riscLockPkg::XLEN-1:0]       rdData,
	output logic [riscLockPkg::XLEN-1:0]       rs1Data,
	output logic [riscLockPkg::XLEN-1:0]       rs2Data
);
	import riscLockPkg::*;

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	// both read ports are combinational
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn && (rdAddr != '0))  // x0 stays zero
		begin
			regs[rdAddr] <= rdData;
		end
	end

endmodule

`default_nettype wire

//--- hw/riscLockCore.sv
`timescale 1ns/1ps
`default_nettype none

module riscLockCore #(
	parameter int IMEM_ADDR_W = 9
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic                         go,
	input  logic [riscLockPkg::XLEN-1:0] startPC,
	input  logic [riscLockPkg::XLEN-1:0] instrData,
	output logic [IMEM_ADDR_W-1:0]       instrAddr,
	output riscLockPkg::lockCmd_t        lockOut,
	output logic                         done,
	output logic                         error,
	output logic [riscLockPkg::XLEN-1:0] out1,
	output logic [riscLockPkg::XLEN-1:0] out2
);
	import riscLockPkg::*;

	logic [REG_ADDR_W-1:0] rs1Addr;
	logic [REG_ADDR_W-1:0] rs2Addr;
	logic [REG_ADDR_W-1:0] rdAddr;
	logic [XLEN-1:0]       rs1Data;
	logic [XLEN-1:0]       rs2Data;
	logic [XLEN-1:0]       rdData;
	logic [XLEN-1:0]       operandB;
	logic [XLEN-1:0]       aluResult;
	logic                  writeEn;
	logic                  takeBranch;
	logic                  altOp;
	logic                  regForm;
	funct3_t               funct3;

	controlFsm #(
		.IMEM_ADDR_W(IMEM_ADDR_W)
	) i_controlFsm (
		.clk, .rst, .start, .go, .startPC, .instrData,
		.aluResult, .takeBranch, .rs1Data, .rs2Data,
		.instrAddr, .rs1Addr, .rs2Addr, .rdAddr, .rdData, .operandB,
		.writeEn, .funct3, .altOp, .regForm,
		.lockOut, .done, .error, .out1, .out2
	);

	regFile i_regFile (
		.clk, .rst, .writeEn, .rs1Addr, .rs2Addr, .rdAddr, .rdData,
		.rs1Data, .rs2Data
	);

	// both units see the same operands, controlFsm picks which result counts
	intAlu i_intAlu (
		.rs1Data, .operandB, .funct3, .altOp, .regForm, .aluResult
	);

	branchCompare i_branchCompare (
		.rs1Data,
		.rs2Data,
		.cond(branch_t'(funct3)),  // branch condition lives in funct3
		.takeBranch
	);

endmodule

`default_nettype wire

//--- hw/riscLockPkg.sv
`default_nettype none

package riscLockPkg;

	parameter int XLEN = 32;       // register and operand width
	parameter int REG_ADDR_W = 5;  // 32 architectural registers

	// major opcodes, bits [6:0] of the instruction word
	typedef enum logic [6:0] {
		OP_HALT   = 7'b0000000,  // all-zero word stops the core
		OP_UNLOCK = 7'b0000001,
		OP_LOCK   = 7'b0000111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_t;

	// integer operations, bit 30 picks SUB and SRA
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} funct3_t;

	// branch conditions share the funct3 field
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_t;

	typedef enum logic [1:0] {
		LOCK_NONE    = 2'd0,
		LOCK_HOLD    = 2'd1,  // waiting for go
		LOCK_RELEASE = 2'd2   // one-cycle release pulse
	} lockCmd_t;

	typedef enum logic [3:0] {
		IDLE, FETCH, LATCH, DECODE, EXEC, PCUPDATE, LOCKWAIT, DONE, ERROR
	} state_t;

endpackage

`default_nettype wire

//--- riscLock.f
+incdir+verif
hw/riscLockPkg.sv
hw/regFile.sv
hw/intAlu.sv
hw/branchCompare.sv
hw/controlFsm.sv
hw/riscLockCore.sv
verif/riscLockTb.sv

//--- verif/riscLockProgram.svh
`ifndef RISCLOCKPROGRAM_SVH
`define RISCLOCKPROGRAM_SVH

// register-register form
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// register-immediate form
function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd);
	return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// expected integer result, written from the instruction set rules
function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
	input logic isReg, input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return (isReg && alt) ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// expected branch decision
function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

`endif

//--- verif/riscLockTb.sv
`timescale 1ns/1ps
`default_nettype none

module riscLockTb;
	import riscLockPkg::*;

	`include "riscLockProgram.svh"

	logic clk = 0;
	logic rst = 0;
	logic start = 0;
	logic go = 0;
	logic [31:0] startPC = 32'h40;
	logic [31:0] instrData = '0;
	logic [8:0] instrAddr;
	lockCmd_t lockOut;
	logic done;
	logic error;
	logic [31:0] out1;
	logic [31:0] out2;

	logic [31:0] mem [512];
	logic [31:0] prog [$];
	logic [31:0] lfsrState = 32'h65776c4f;
	logic [31:0] expOut1 = '0;
	logic [31:0] expOut2 = '0;
	logic preStart = 0;
	logic checkOut = 0;
	logic expectError = 0;
	logic running = 0;
	string testName = "none";
	int errors = 0;
	int cycles = 0;
	int cycleLimit = 50;
	int holdCount = 0;
	int releaseCount = 0;

	riscLockCore #(.IMEM_ADDR_W(9)) i_riscLockCore (
		.clk, .rst, .start, .go, .startPC, .instrData,
		.instrAddr, .lockOut, .done, .error, .out1, .out2
	);

	always #4 clk = ~clk;

	always @(posedge clk) instrData <= #1 mem[instrAddr];  // one cycle read latency

	always @(posedge clk)
	begin
		if (lockOut == LOCK_HOLD) holdCount++;
		if (lockOut == LOCK_RELEASE) releaseCount++;
		if (running)
		begin
			cycles++;
			if (cycles > cycleLimit)
			begin
				$display("timeout: no done or error within %0d cycles", cycleLimit);
				$display("Checks failed");
				$finish;
			end
		end
	end

	aPreStart: assert property (@(posedge clk) disable iff (!rst) preStart |->
		(!done && !error && lockOut == LOCK_NONE && instrAddr == startPC[10:2]))
	else
	begin
		errors++;
		$display("%s: outputs not idle before start", testName);
	end
	aOut1: assert property (@(posedge clk) disable iff (!rst) checkOut |-> out1 == expOut1)
	else
	begin
		errors++;
		$display("ERROR %s out1 expected %h actual %h", testName, expOut1, out1);
	end
	aOut2: assert property (@(posedge clk) disable iff (!rst) checkOut |-> out2 == expOut2)
	else
	begin
		errors++;
		$display("ERROR %s out2 expected %h actual %h", testName, expOut2, out2);
	end
	aHoldStays: assert property (@(posedge clk) disable iff (!rst)
		(lockOut == LOCK_HOLD && !go) |=> lockOut == LOCK_HOLD)
	else
	begin
		errors++;
		$display("%s: lock hold dropped while go was low", testName);
	end
	aHoldAddr: assert property (@(posedge clk) disable iff (!rst)
		(lockOut == LOCK_HOLD && $past(lockOut) == LOCK_HOLD) |-> $stable(instrAddr))
	else
	begin
		errors++;
		$display("%s: instrAddr moved during lock wait", testName);
	end
	aReleaseOnce: assert property (@(posedge clk) disable iff (!rst)
		lockOut == LOCK_RELEASE |=> lockOut == LOCK_NONE)
	else
	begin
		errors++;
		$display("%s: release pulse longer than one cycle", testName);
	end
	aErrorSticky: assert property (@(posedge clk) disable iff (!rst)
		error |=> (error && !done && $stable(instrAddr)))
	else
	begin
		errors++;
		$display("%s: error state was not sticky", testName);
	end
	aErrorExpected: assert property (@(posedge clk) disable iff (!rst) error |-> expectError)
	else
	begin
		errors++;
		$display("%s: unexpected error state", testName);
	end
	aDoneExpected: assert property (@(posedge clk) disable iff (!rst) done |-> !expectError)
	else
	begin
		errors++;
		$display("%s: done rose on an illegal program", testName);
	end

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return r;
	endfunction

	task automatic driveGo(input int waitCycles);
		while (lockOut != LOCK_HOLD)
		begin
			@(posedge clk);
			#1;
		end
		repeat (waitCycles) @(posedge clk);
		#1 go = 1;
		@(posedge clk);
		#1 go = 0;
	endtask

	task automatic runProgram(input string name, input logic [31:0] e1, input logic [31:0] e2,
		input int lockWait, input bit wantError);
		int base;
		base = int'(startPC[10:2]);
		rst = 0;
		running = 0;
		testName = name;
		expOut1 = e1;
		expOut2 = e2;
		expectError = wantError;
		for (int i = 0; i < 512; i++) mem[i] = '0;
		foreach (prog[i]) mem[base + i] = prog[i];
		repeat (10) @(posedge clk);
		#1 rst = 1;
		holdCount = 0;
		releaseCount = 0;
		preStart = 1;
		repeat (2) @(posedge clk);
		#1 preStart = 0;
		start = 1;
		running = 1;
		cycleLimit += 5 * prog.size() + lockWait;
		@(posedge clk);
		#1 start = 0;
		fork
			while (!done && !error)
			begin
				@(posedge clk);
				#1;
			end
			if (lockWait > 0) driveGo(lockWait);
		join
		repeat (wantError ? 5 : 2) @(posedge clk);
		#1 checkOut = !wantError;
		@(posedge clk);
		#1 checkOut = 0;
		prog.delete();
	endtask

	initial
	begin
		logic [2:0] rF3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic rAlt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		logic [2:0] iF3 [9] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [11:0] a;
		logic [11:0] b;
		logic [11:0] imm;
		logic [31:0] e1;
		int waitCycles;

		for (int i = 0; i < 10; i++)
		begin
			a = 12'(randBits(12));
			b = 12'(randBits(12));
			imm = 12'(randBits(12));
			// bit 10 of a shift immediate picks SRAI
			if (iF3[i % 9] == 3'd1 || iF3[i % 9] == 3'd5)
				imm = {1'b0, (i % 9 == 6), 5'b0, imm[4:0]};
			prog = '{encI(a, 5'd0, 3'd0, 5'd0), encI(a, 5'd0, 3'd0, 5'd1),
				encI(b, 5'd0, 3'd0, 5'd2), encR({1'b0, rAlt[i], 5'b0}, 5'd2, 5'd1, rF3[i], 5'd31),
				encI(imm, 5'd1, iF3[i % 9], 5'd30), 32'h0};
			runProgram($sformatf("int%0d", i), refAlu(rF3[i], rAlt[i], 1'b1, sext12(a), sext12(b)),
				refAlu(iF3[i % 9], imm[10], 1'b0, sext12(a), sext12(imm)), 0, 0);
		end

		foreach (conds[k])
		begin
			a = 12'(randBits(12));
			b = 12'(randBits(12));
			e1 = '0;
			if (!refBranch(conds[k], sext12(a), sext12(b))) e1 += 1;
			if (!refBranch(conds[k], sext12(b), sext12(a))) e1 += 2;
			if (!refBranch(conds[k], sext12(a), sext12(a))) e1 += 4;
			prog = '{encI(a, 5'd0, 3'd0, 5'd1), encI(b, 5'd0, 3'd0, 5'd2),
				encB(13'd8, 5'd2, 5'd1, conds[k]), encI(12'd1, 5'd31, 3'd0, 5'd31),
				encB(13'd8, 5'd1, 5'd2, conds[k]), encI(12'd2, 5'd31, 3'd0, 5'd31),
				encB(13'd8, 5'd1, 5'd1, conds[k]), encI(12'd4, 5'd31, 3'd0, 5'd31), 32'h0};
			runProgram($sformatf("branch%0d", conds[k]), e1, 32'h0, 0, 0);
		end

		// jump at startPC+4 links startPC+8
		prog = '{encI(12'd1, 5'd0, 3'd0, 5'd31), encJ(21'd8, 5'd30),
			encI(12'd2, 5'd31, 3'd0, 5'd31), 32'h0};
		runProgram("jal", 32'd1, startPC + 32'd8, 0, 0);

		a = 12'(randBits(12));
		b = 12'(randBits(12));
		waitCycles = int'(randBits(4)) + 1;
		prog = '{encI(a, 5'd0, 3'd0, 5'd31), 32'h7, 32'h1, encI(b, 5'd0, 3'd0, 5'd30), 32'h0};
		runProgram("lock", sext12(a), sext12(b), waitCycles, 0);
		assert (holdCount == waitCycles + 1 && releaseCount == 1)
		else
		begin
			errors++;
			$display("ERROR %s hold/release cycles expected %0d/1 actual %0d/%0d",
				testName, waitCycles + 1, holdCount, releaseCount);
		end

		prog = '{encI(12'd1, 5'd0, 3'd0, 5'd31), 32'h7f, 32'h0};
		runProgram("illegal", 32'h0, 32'h0, 0, 1);

		$display("riscLockTb finished with %0d errors", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
